//--- board_ctrl_pkg.sv
/*
 * Board control package
 * Bus widths, register map and timing constants shared by the
 * register file, RTC divider and fan PWM generator
 */

package board_ctrl_pkg;

  //////////////////////////////
  // Bus and I/O widths
  //////////////////////////////

  // Wishbone word address and data
  localparam int WB_ADR_W = 4;
  localparam int WB_DAT_W = 32;

  localparam int NUM_LED = 8;

  // Fan setting and board switches share one width
  localparam int FAN_W = 4;

  //////////////////////////////
  // Fan PWM timing
  //////////////////////////////

  localparam int PWM_STEPS    = 2 ** FAN_W;
  localparam int PWM_PRESCALE = 4;

  localparam int                    PRESCALE_W   = $clog2(PWM_PRESCALE);
  localparam logic [PRESCALE_W-1:0] PRESCALE_MAX = PRESCALE_W'(PWM_PRESCALE - 1);
  localparam logic [FAN_W-1:0]      STEP_MAX     = FAN_W'(PWM_STEPS - 1);

  //////////////////////////////
  // RTC divider timing
  //////////////////////////////

  // Half period of rtc_o in soc_clk cycles, full period is 50
  localparam int RTC_HALF_PERIOD = 25;

  localparam int                   RTC_CNT_W   = $clog2(RTC_HALF_PERIOD);
  localparam logic [RTC_CNT_W-1:0] RTC_CNT_MAX = RTC_CNT_W'(RTC_HALF_PERIOD - 1);

  //////////////////////////////
  // Register map
  //////////////////////////////

  // Word addresses, anything above REG_FAN_OVR is unmapped
  typedef enum logic [WB_ADR_W-1:0] {
    REG_LED     = 4'd0,
    REG_FAN_CTL = 4'd1,
    REG_FAN_OVR = 4'd2
  } reg_addr_e;

endpackage

//--- cfg_regs.sv
/*
 * Board configuration register file
 * Wishbone classic slave holding the LED, fan setting and fan
 * override registers, one-cycle ack with no wait states
 */

`timescale 1ns/1ns

module cfg_regs import board_ctrl_pkg::*; (
  input  logic                soc_clk,
  input  logic                rst_n,
  input  logic                wb_cyc_i,
  input  logic                wb_stb_i,
  input  logic                wb_we_i,
  input  reg_addr_e           wb_adr_i,
  input  logic [WB_DAT_W-1:0] wb_dat_i,
  input  logic [FAN_W-1:0]    fan_sw_i,
  output logic                wb_ack_o,
  output logic [WB_DAT_W-1:0] wb_dat_o,
  output logic [NUM_LED-1:0]  led_o,
  output logic [FAN_W-1:0]    fan_setting_o
);

  logic                ack_q;
  logic [WB_DAT_W-1:0] rdata_q;
  logic [WB_DAT_W-1:0] rdata_d;
  logic [NUM_LED-1:0]  led_q;
  logic [FAN_W-1:0]    fan_q;
  logic                ovr_q;

  logic req;
  logic wr_req;
  logic rd_req;

  //////////////////////////////
  // Bus handshake
  //////////////////////////////

  // New request only while no ack is pending, so each transfer acks once
  assign req    = wb_cyc_i & wb_stb_i & ~ack_q;
  assign wr_req = req & wb_we_i;
  assign rd_req = req & ~wb_we_i;

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      led_q <= '0;
      ovr_q <= 1'b0;
    end else if (wr_req) begin
      case (wb_adr_i)
        REG_LED:     led_q <= wb_dat_i[NUM_LED-1:0];
        REG_FAN_OVR: ovr_q <= wb_dat_i[0];
        default: ;
      endcase
    end
  end

  // Switches win over the bus unless software holds the override
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      fan_q <= '0;
    end else if (!ovr_q) begin
      fan_q <= fan_sw_i;
    end else if (wr_req && wb_adr_i == REG_FAN_CTL) begin
      fan_q <= wb_dat_i[FAN_W-1:0];
    end
  end

  //////////////////////////////
  // Read path
  //////////////////////////////

  // Unused upper bits and unmapped addresses read as zero
  always_comb begin
    rdata_d = '0;
    case (wb_adr_i)
      REG_LED:     rdata_d[NUM_LED-1:0] = led_q;
      REG_FAN_CTL: rdata_d[FAN_W-1:0]   = fan_q;
      REG_FAN_OVR: rdata_d[0]           = ovr_q;
      default: ;
    endcase
  end

  // Data bus stays low outside the ack cycle of a read
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (rd_req) begin
      rdata_q <= rdata_d;
    end else begin
      rdata_q <= '0;
    end
  end

  assign wb_ack_o      = ack_q;
  assign wb_dat_o      = rdata_q;
  assign led_o         = led_q;
  assign fan_setting_o = fan_q;

  //////////////////////////////
  // Assertions
  //////////////////////////////

  // Master holds its request through ack, the slave must not ack it twice
  a_ack_single: assert property (
    @(posedge soc_clk) disable iff (!rst_n)
    wb_ack_o |=> !wb_ack_o
  ) else $error("wb_ack_o high in two consecutive cycles");

  // Ack answers a request seen in the cycle before
  a_ack_after_req: assert property (
    @(posedge soc_clk) disable iff (!rst_n)
    wb_ack_o |-> $past(wb_cyc_i && wb_stb_i)
  ) else $error("wb_ack_o without a request in the previous cycle");

endmodule

//--- rtc_divider.sv
/*
 * RTC divider
 * Free-running divide-by-50 of soc_clk into the rtc_o square wave
 */

`timescale 1ns/1ns

module rtc_divider import board_ctrl_pkg::*; (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_o
);

  logic [RTC_CNT_W-1:0] cnt_q;
  logic [RTC_CNT_W-1:0] cnt_d;
  logic                 rtc_q;
  logic                 rtc_d;
  logic                 wrap;

  //////////////////////////////
  // Half period counter
  //////////////////////////////

  assign wrap = (cnt_q == RTC_CNT_MAX);

  // Toggle the output once per half period
  always_comb begin
    cnt_d = cnt_q + 1'b1;
    rtc_d = rtc_q;
    if (wrap) begin
      cnt_d = '0;
      rtc_d = ~rtc_q;
    end
  end

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
      rtc_q <= 1'b0;
    end else begin
      cnt_q <= cnt_d;
      rtc_q <= rtc_d;
    end
  end

  assign rtc_o = rtc_q;

  // Counter width allows values past the wrap point
  a_cnt_range: assert property (
    @(posedge soc_clk) disable iff (!rst_n)
    cnt_q <= RTC_CNT_MAX
  ) else $error("RTC counter beyond half period");

endmodule

//--- fan_pwm.sv
/*
 * Fan PWM generator
 * 16-step PWM with prescaler, duty taken from the fan setting
 * sampled at each period start
 */

`timescale 1ns/1ns

module fan_pwm import board_ctrl_pkg::*; (
  input  logic             soc_clk,
  input  logic             rst_n,
  input  logic [FAN_W-1:0] fan_setting_i,
  output logic             fan_pwm_o
);

  logic [PRESCALE_W-1:0] pre_q;
  logic [FAN_W-1:0]      step_q;
  logic [FAN_W-1:0]      setting_q;

  logic step_adv;
  logic period_end;

  //////////////////////////////
  // Period counters
  //////////////////////////////

  assign step_adv   = (pre_q == PRESCALE_MAX);
  assign period_end = step_adv && (step_q == STEP_MAX);

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      pre_q <= '0;
    end else if (step_adv) begin
      pre_q <= '0;
    end else begin
      pre_q <= pre_q + 1'b1;
    end
  end

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      step_q <= '0;
    end else if (period_end) begin
      step_q <= '0;
    end else if (step_adv) begin
      step_q <= step_q + 1'b1;
    end
  end

  //////////////////////////////
  // Duty compare
  //////////////////////////////

  // Sample once per period so a change mid-period cannot glitch the output
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      setting_q <= '0;
    end else if (period_end) begin
      setting_q <= fan_setting_i;
    end
  end

  // High for the first setting steps of each period
  assign fan_pwm_o = (step_q < setting_q);

  // Fan fully off for setting 0
  a_off_at_zero: assert property (
    @(posedge soc_clk) disable iff (!rst_n)
    (setting_q == '0) |-> !fan_pwm_o
  ) else $error("fan_pwm_o high with zero setting");

endmodule

//--- board_ctrl_top.sv
/*
 * Board control top level
 * Register file, RTC divider and fan PWM generator beside the SoC
 */

`timescale 1ns/1ns

module board_ctrl_top import board_ctrl_pkg::*; (
  input  logic                soc_clk,
  input  logic                rst_n,
  input  logic                wb_cyc_i,
  input  logic                wb_stb_i,
  input  logic                wb_we_i,
  input  reg_addr_e           wb_adr_i,
  input  logic [WB_DAT_W-1:0] wb_dat_i,
  output logic                wb_ack_o,
  output logic [WB_DAT_W-1:0] wb_dat_o,
  input  logic [FAN_W-1:0]    fan_sw_i,
  output logic [NUM_LED-1:0]  led_o,
  output logic                fan_pwm_o,
  output logic                rtc_o
);

  logic [FAN_W-1:0] fan_setting;

  //////////////////////////////
  // Register file
  //////////////////////////////

  // LEDs leave straight from their register
  cfg_regs u_cfg_regs (
    .soc_clk       ( soc_clk     ),
    .rst_n         ( rst_n       ),
    .wb_cyc_i      ( wb_cyc_i    ),
    .wb_stb_i      ( wb_stb_i    ),
    .wb_we_i       ( wb_we_i     ),
    .wb_adr_i      ( wb_adr_i    ),
    .wb_dat_i      ( wb_dat_i    ),
    .fan_sw_i      ( fan_sw_i    ),
    .wb_ack_o      ( wb_ack_o    ),
    .wb_dat_o      ( wb_dat_o    ),
    .led_o         ( led_o       ),
    .fan_setting_o ( fan_setting )
  );

  //////////////////////////////
  // RTC
  //////////////////////////////

  rtc_divider u_rtc_divider (
    .soc_clk ( soc_clk ),
    .rst_n   ( rst_n   ),
    .rtc_o   ( rtc_o   )
  );

  //////////////////////////////
  // Fan control
  //////////////////////////////

  fan_pwm u_fan_pwm (
    .soc_clk       ( soc_clk     ),
    .rst_n         ( rst_n       ),
    .fan_setting_i ( fan_setting ),
    .fan_pwm_o     ( fan_pwm_o   )
  );

endmodule

//--- tb_board_ctrl.sv
/*
 * Board control testbench
 * LCG-driven Wishbone traffic and fan switch stimulus checked against
 * a register model, plus PWM duty and RTC divider timing
 */

`timescale 1ns/1ns

module tb_board_ctrl import board_ctrl_pkg::*; ();

  localparam logic [31:0] SEED         = 32'h4a7e_a245;
  localparam int          CLK_HALF     = 50;
  localparam int          RESET_CYCLES = 5;
  localparam int          LED_ITER     = 40;
  localparam int          FAN_ITER     = 12;
  localparam int          PWM_ITER     = 8;
  localparam int          RTC_GAPS     = 10;
  localparam int          UNMAP_ITER   = 10;
  localparam int          PWM_PERIOD   = PWM_STEPS * PWM_PRESCALE;

  // Worst case cycles per Wishbone transfer
  localparam int BUS_CYC = 3;

  // Sum of all test lengths plus margin
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + 4 * BUS_CYC
                                + LED_ITER * 2 * BUS_CYC
                                + FAN_ITER * 6 * BUS_CYC + 4 * BUS_CYC
                                + PWM_ITER * (BUS_CYC + 4 * PWM_PERIOD)
                                + (RTC_GAPS + 2) * 2 * RTC_HALF_PERIOD
                                + UNMAP_ITER * 5 * BUS_CYC + 500;

  logic                soc_clk;
  logic                rst_n;
  logic                wb_cyc;
  logic                wb_stb;
  logic                wb_we;
  reg_addr_e           wb_adr;
  logic [WB_DAT_W-1:0] wb_dat_w;
  logic                wb_ack;
  logic [WB_DAT_W-1:0] wb_dat_r;
  logic [FAN_W-1:0]    fan_sw;
  logic [NUM_LED-1:0]  led;
  logic                fan_pwm;
  logic                rtc;

  // Register model
  logic [NUM_LED-1:0] led_m;
  logic [FAN_W-1:0]   fan_m;
  logic               ovr_m;

  logic [31:0] lcg_state;
  int          cycle_cnt = 0;

  board_ctrl_top u_dut (
    .soc_clk   ( soc_clk  ),
    .rst_n     ( rst_n    ),
    .wb_cyc_i  ( wb_cyc   ),
    .wb_stb_i  ( wb_stb   ),
    .wb_we_i   ( wb_we    ),
    .wb_adr_i  ( wb_adr   ),
    .wb_dat_i  ( wb_dat_w ),
    .wb_ack_o  ( wb_ack   ),
    .wb_dat_o  ( wb_dat_r ),
    .fan_sw_i  ( fan_sw   ),
    .led_o     ( led      ),
    .fan_pwm_o ( fan_pwm  ),
    .rtc_o     ( rtc      )
  );

  initial begin
    soc_clk = 1'b0;
    forever #CLK_HALF soc_clk = ~soc_clk;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "Simulation stopped on the first failure");
  endtask

  always @(posedge soc_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      fail_run("Timeout, the run took more cycles than all tests need");
    end
  end

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      fail_run($sformatf("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, exp, got));
    end
  endtask

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // One classic cycle, request held until ack
  task automatic wb_transfer(input logic we, input logic [WB_ADR_W-1:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    waited = 0;
    @(negedge soc_clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = reg_addr_e'(addr);
    wb_dat_w = wdata;
    do begin
      @(negedge soc_clk);
      waited++;
    end while (!wb_ack);
    check_val("ack latency", 32'd1, 32'(waited));
    rdata    = wb_dat_r;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_dat_w = '0;
  endtask

  task automatic write_reg(input logic [WB_ADR_W-1:0] addr, input logic [31:0] data);
    logic [31:0] discard;
    wb_transfer(1'b1, addr, data, discard);
  endtask

  task automatic read_reg(input logic [WB_ADR_W-1:0] addr, output logic [31:0] data);
    wb_transfer(1'b0, addr, '0, data);
  endtask

  task automatic compare_model(input string name);
    logic [31:0] rd;
    read_reg(REG_LED, rd);
    check_val({name, " led"}, 32'(led_m), rd);
    read_reg(REG_FAN_CTL, rd);
    check_val({name, " fan"}, 32'(fan_m), rd);
    read_reg(REG_FAN_OVR, rd);
    check_val({name, " override"}, 32'(ovr_m), rd);
    check_val({name, " led_o"}, 32'(led_m), 32'(led));
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic reset_values();
    logic [31:0] rd;
    check_val("reset ack", 32'd0, 32'(wb_ack));
    check_val("reset led_o", 32'd0, 32'(led));
    check_val("reset fan_pwm_o", 32'd0, 32'(fan_pwm));
    check_val("reset rtc_o", 32'd0, 32'(rtc));
    read_reg(REG_FAN_OVR, rd);
    check_val("reset override", 32'd0, rd);
  endtask

  task automatic led_traffic();
    logic [31:0] r;
    logic [31:0] rd;
    for (int i = 0; i < LED_ITER; i++) begin
      r = next_rand();
      write_reg(REG_LED, r);
      led_m = r[NUM_LED-1:0];
      check_val("led_o after write", 32'(led_m), 32'(led));
      read_reg(REG_LED, rd);
      check_val("led read", 32'(led_m), rd);
    end
  endtask

  task automatic fan_source();
    logic [31:0]      r;
    logic [31:0]      rd;
    logic [FAN_W-1:0] sw;
    for (int i = 0; i < FAN_ITER; i++) begin
      r  = next_rand();
      sw = r[FAN_W-1:0];
      @(negedge soc_clk);
      fan_sw = sw;
      fan_m  = sw;
      read_reg(REG_FAN_CTL, rd);
      check_val("fan follows switches", 32'(fan_m), rd);
      // Switches overwrite this on the next edge
      write_reg(REG_FAN_CTL, 32'(~sw));
      read_reg(REG_FAN_CTL, rd);
      check_val("fan write lost", 32'(fan_m), rd);
    end
    write_reg(REG_FAN_OVR, 32'd1);
    ovr_m = 1'b1;
    read_reg(REG_FAN_OVR, rd);
    check_val("override set", 32'(ovr_m), rd);
    for (int i = 0; i < FAN_ITER; i++) begin
      r = next_rand();
      write_reg(REG_FAN_CTL, r);
      fan_m = r[FAN_W-1:0];
      @(negedge soc_clk);
      fan_sw = r[2*FAN_W-1:FAN_W];
      read_reg(REG_FAN_CTL, rd);
      check_val("fan override write", 32'(fan_m), rd);
    end
  endtask

  task automatic measure_duty(input logic [FAN_W-1:0] setting);
    int high_cnt;
    high_cnt = 0;
    write_reg(REG_FAN_CTL, 32'(setting));
    fan_m = setting;
    // One full period so the new setting is latched
    repeat (PWM_PERIOD) @(negedge soc_clk);
    if (setting != '0) begin
      // Skip the high part, the next rise is step 0
      while (fan_pwm) @(negedge soc_clk);
      while (!fan_pwm) @(negedge soc_clk);
    end
    repeat (PWM_PERIOD) begin
      if (fan_pwm) high_cnt++;
      @(negedge soc_clk);
    end
    check_val("pwm high cycles", 32'(int'(setting) * PWM_PRESCALE), 32'(high_cnt));
  endtask

  task automatic pwm_duty();
    logic [31:0]      r;
    logic [FAN_W-1:0] setting;
    for (int i = 0; i < PWM_ITER; i++) begin
      r       = next_rand();
      setting = (i == 0) ? '0 : r[FAN_W-1:0];
      measure_duty(setting);
    end
  endtask

  task automatic rtc_gaps();
    logic prev;
    int   gap;
    @(negedge soc_clk);
    prev = rtc;
    while (rtc == prev) @(negedge soc_clk);
    for (int i = 0; i < RTC_GAPS; i++) begin
      prev = rtc;
      gap  = 0;
      do begin
        @(negedge soc_clk);
        gap++;
      end while (rtc == prev);
      check_val("rtc gap", 32'(RTC_HALF_PERIOD), 32'(gap));
    end
  endtask

  task automatic unmapped_space();
    logic [31:0]         r;
    logic [31:0]         rd;
    logic [WB_ADR_W-1:0] addr;
    for (int i = 0; i < UNMAP_ITER; i++) begin
      r    = next_rand();
      addr = WB_ADR_W'(3 + r % 13);
      @(negedge soc_clk);
      fan_sw = r[FAN_W-1:0];
      write_reg(addr, next_rand());
      read_reg(addr, rd);
      check_val("unmapped read", 32'd0, rd);
      compare_model("unmapped write");
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    lcg_state = SEED;
    rst_n     = 1'b0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = REG_LED;
    wb_dat_w  = '0;
    fan_sw    = '0;
    led_m     = '0;
    fan_m     = '0;
    ovr_m     = 1'b0;
    repeat (RESET_CYCLES) @(negedge soc_clk);
    rst_n = 1'b1;

    reset_values();
    led_traffic();
    fan_source();
    pwm_duty();
    rtc_gaps();
    unmapped_space();

    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- files.f
board_ctrl_pkg.sv
cfg_regs.sv
rtc_divider.sv
fan_pwm.sv
board_ctrl_top.sv
tb_board_ctrl.sv

//--- Makefile
# Verilator build and run for the board control testbench

SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_board_ctrl
FILELIST := files.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SRCS     := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(FILELIST) $(SRCS)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the binary is the pass or fail result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
